//--- minrv32_params.svh
`ifndef MINRV32_PARAMS_SVH
`define MINRV32_PARAMS_SVH

// fixed by the RV32I ISA
`define MINRV32_XLEN     32
`define MINRV32_REG_AW   5
`define MINRV32_NUM_REGS 32

// boot address and initial stack pointer (x2)
`define MINRV32_PROGADDR_RESET 32'h0001_0000
`define MINRV32_STACKADDR      32'h0001_0000

`endif

//--- minrv32_pkg.sv
package minrv32_pkg;

	// major opcodes, insn[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	// same values as funct3 of the branch opcode
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branch_cond_t;

	typedef enum logic [1:0] {
		WB_ALU,  // alu result, lui goes through here too
		WB_IMM,  // upper immediate added to pc (auipc)
		WB_PC4,  // link address
		WB_MEM   // load data
	} wb_sel_t;

	typedef enum logic [1:0] {
		OPND_RS1,
		OPND_RS2,
		OPND_READY
	} opnd_state_t;

endpackage

//--- minrv32_decode.sv
`include "minrv32_params.svh"

module minrv32_decode (
	input  logic [`MINRV32_XLEN-1:0]   insn,
	output logic [`MINRV32_REG_AW-1:0] rs1_addr,
	output logic [`MINRV32_REG_AW-1:0] rs2_addr,
	output logic [`MINRV32_REG_AW-1:0] rd_addr,
	output logic                       rs1_used,
	output logic                       rs2_used,
	output logic                       rd_we,
	output logic [`MINRV32_XLEN-1:0]   imm,
	output minrv32_pkg::alu_op_t       alu_op,
	output logic                       use_imm,
	output minrv32_pkg::wb_sel_t       wb_sel,
	output logic                       is_jal,
	output logic                       is_jalr,
	output logic                       is_branch,
	output logic                       is_load,
	output logic                       is_store,
	output logic                       illegal
);
	import minrv32_pkg::*;

	opcode_t                  opcode;
	logic [2:0]               funct3;
	logic [6:0]               funct7;
	logic [`MINRV32_XLEN-1:0] imm_i;
	logic [`MINRV32_XLEN-1:0] imm_s;
	logic [`MINRV32_XLEN-1:0] imm_b;
	logic [`MINRV32_XLEN-1:0] imm_u;
	logic [`MINRV32_XLEN-1:0] imm_j;

	assign opcode   = opcode_t'(insn[6:0]);
	assign funct3   = insn[14:12];
	assign funct7   = insn[31:25];
	assign rd_addr  = insn[11:7];
	assign rs1_addr = insn[19:15];
	assign rs2_addr = insn[24:20];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	always_comb begin
		rs1_used  = 1'b0;
		rs2_used  = 1'b0;
		rd_we     = 1'b0;
		imm       = imm_i;
		alu_op    = ALU_ADD;
		use_imm   = 1'b1;
		wb_sel    = WB_ALU;
		is_jal    = 1'b0;
		is_jalr   = 1'b0;
		is_branch = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		illegal   = 1'b0;
		case (opcode)
			OPC_LUI: begin  // x0 + imm through the alu
				rd_we = 1'b1;
				imm   = imm_u;
			end
			OPC_AUIPC: begin
				rd_we  = 1'b1;
				imm    = imm_u;
				wb_sel = WB_IMM;
			end
			OPC_JAL: begin
				rd_we  = 1'b1;
				imm    = imm_j;
				wb_sel = WB_PC4;
				is_jal = 1'b1;
			end
			OPC_JALR: begin
				rs1_used = 1'b1;
				rd_we    = 1'b1;
				wb_sel   = WB_PC4;
				is_jalr  = 1'b1;
				illegal  = funct3 != 3'b000;
			end
			OPC_BRANCH: begin
				rs1_used  = 1'b1;
				rs2_used  = 1'b1;
				imm       = imm_b;
				use_imm   = 1'b0;
				is_branch = 1'b1;
				illegal   = funct3[2:1] == 2'b01;  // 010 and 011 are reserved
			end
			OPC_LOAD: begin
				rs1_used = 1'b1;
				rd_we    = 1'b1;
				wb_sel   = WB_MEM;
				is_load  = 1'b1;
				illegal  = funct3 != 3'b010;  // lw only
			end
			OPC_STORE: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				imm      = imm_s;
				is_store = 1'b1;
				illegal  = funct3 != 3'b010;  // sw only
			end
			OPC_OP_IMM, OPC_OP: begin
				rs1_used = 1'b1;
				rd_we    = 1'b1;
				use_imm  = opcode == OPC_OP_IMM;
				rs2_used = opcode == OPC_OP;
				// funct7 must be zero unless overridden below
				illegal  = (opcode == OPC_OP) && (funct7 != 7'b0);
				case (funct3)
					3'b000: begin
						alu_op  = (!use_imm && funct7[5]) ? ALU_SUB : ALU_ADD;
						illegal = !use_imm && ((funct7 & 7'b1011111) != 7'b0);
					end
					3'b001: begin
						alu_op  = ALU_SLL;
						illegal = funct7 != 7'b0;
					end
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b101: begin
						alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
						illegal = (funct7 & 7'b1011111) != 7'b0;
					end
					3'b110: alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
			end
			default: illegal = 1'b1;  // includes SYSTEM, no csrs here
		endcase
	end

endmodule

//--- minrv32_operand_fetch.sv
`include "minrv32_params.svh"

module minrv32_operand_fetch (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic [`MINRV32_REG_AW-1:0] rs1_addr,
	input  logic [`MINRV32_REG_AW-1:0] rs2_addr,
	input  logic                       rs1_used,
	input  logic                       rs2_used,
	input  logic [`MINRV32_REG_AW-1:0] rd_addr,
	input  logic                       rd_we,
	input  logic [`MINRV32_XLEN-1:0]   rd_wdata,
	input  logic                       insn_complete,
	output logic [`MINRV32_XLEN-1:0]   rs1_value,
	output logic [`MINRV32_XLEN-1:0]   rs2_value,
	output logic                       operands_ready
);
	import minrv32_pkg::*;

	logic [`MINRV32_XLEN-1:0]   regs [`MINRV32_NUM_REGS];
	opnd_state_t                state;
	logic                       read_rs1;
	logic                       read_rs2;
	logic [`MINRV32_REG_AW-1:0] port_addr;
	logic [`MINRV32_XLEN-1:0]   port_data;
	logic [`MINRV32_XLEN-1:0]   rs1_cache;
	logic [`MINRV32_XLEN-1:0]   rs2_cache;

	// one read port, rs1 gets it first
	assign read_rs1  = (state == OPND_RS1) && rs1_used;
	assign read_rs2  = !read_rs1 && (state != OPND_READY) && rs2_used;
	assign port_addr = read_rs1 ? rs1_addr : rs2_addr;
	assign port_data = (port_addr == '0) ? '0 : regs[port_addr];  // x0 reads zero

	always_comb begin
		case (state)
			OPND_RS1: operands_ready = !rs1_used && !rs2_used;
			OPND_RS2: operands_ready = !rs2_used;
			default:  operands_ready = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= OPND_RS1;
		end else if (insn_complete) begin
			state <= OPND_RS1;  // drop cache for the next instruction
		end else if (read_rs1) begin
			state <= rs2_used ? OPND_RS2 : OPND_READY;
		end else if (read_rs2) begin
			state <= OPND_READY;
		end
	end

	always_ff @(posedge clk) begin
		if (read_rs1)
			rs1_cache <= port_data;
		if (read_rs2)
			rs2_cache <= port_data;
	end

	// unused sources read as zero, lui relies on it
	assign rs1_value = rs1_used ? rs1_cache : '0;
	assign rs2_value = rs2_used ? rs2_cache : '0;

	always_ff @(posedge clk) begin
		if (!resetn)
			regs[2] <= `MINRV32_STACKADDR;  // sp
		else if (insn_complete && rd_we && rd_addr != '0)
			regs[rd_addr] <= rd_wdata;
	end

	// once collected, operands stay until the instruction retires
	a_ready_held: assert property (@(posedge clk) disable iff (!resetn)
		operands_ready && !insn_complete |=> operands_ready);

endmodule

//--- minrv32_alu.sv
`include "minrv32_params.svh"

module minrv32_alu (
	input  logic [`MINRV32_XLEN-1:0]  rs1_value,
	input  logic [`MINRV32_XLEN-1:0]  rs2_value,
	input  logic [`MINRV32_XLEN-1:0]  imm,
	input  logic                      use_imm,
	input  minrv32_pkg::alu_op_t      alu_op,
	input  minrv32_pkg::branch_cond_t branch_cond,
	output logic [`MINRV32_XLEN-1:0]  result,
	output logic                      branch_taken
);
	import minrv32_pkg::*;

	logic [`MINRV32_XLEN-1:0] op_b;
	logic [4:0]               shamt;
	logic                     eq;
	logic                     lt_s;
	logic                     lt_u;

	assign op_b  = use_imm ? imm : rs2_value;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_SUB:  result = rs1_value - op_b;
			ALU_SLL:  result = rs1_value << shamt;
			ALU_SLT:  result = {{(`MINRV32_XLEN-1){1'b0}}, $signed(rs1_value) < $signed(op_b)};
			ALU_SLTU: result = {{(`MINRV32_XLEN-1){1'b0}}, rs1_value < op_b};
			ALU_XOR:  result = rs1_value ^ op_b;
			ALU_SRL:  result = rs1_value >> shamt;
			ALU_SRA:  result = $signed(rs1_value) >>> shamt;
			ALU_OR:   result = rs1_value | op_b;
			ALU_AND:  result = rs1_value & op_b;
			default:  result = rs1_value + op_b;  // add, also addresses
		endcase
	end

	// branches always compare the two registers
	assign eq   = rs1_value == rs2_value;
	assign lt_s = $signed(rs1_value) < $signed(rs2_value);
	assign lt_u = rs1_value < rs2_value;

	always_comb begin
		case (branch_cond)
			BR_BEQ:  branch_taken = eq;
			BR_BNE:  branch_taken = !eq;
			BR_BLT:  branch_taken = lt_s;
			BR_BGE:  branch_taken = !lt_s;
			BR_BLTU: branch_taken = lt_u;
			BR_BGEU: branch_taken = !lt_u;
			default: branch_taken = 1'b0;  // reserved, decoder traps
		endcase
	end

endmodule

//--- minrv32_exec.sv
`include "minrv32_params.svh"

module minrv32_exec (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     insn_valid,
	input  logic                     operands_ready,
	input  logic [`MINRV32_XLEN-1:0] imm,
	input  minrv32_pkg::wb_sel_t     wb_sel,
	input  logic                     is_jal,
	input  logic                     is_jalr,
	input  logic                     is_branch,
	input  logic                     is_load,
	input  logic                     is_store,
	input  logic                     illegal,
	input  logic [`MINRV32_XLEN-1:0] alu_result,
	input  logic                     branch_taken,
	input  logic [`MINRV32_XLEN-1:0] rs1_value,
	input  logic [`MINRV32_XLEN-1:0] rs2_value,
	input  logic                     mem_ready,
	input  logic [`MINRV32_XLEN-1:0] mem_rdata,
	output logic [`MINRV32_XLEN-1:0] insn_addr,
	output logic [`MINRV32_XLEN-1:0] rd_wdata,
	output logic                     insn_complete,
	output logic                     mem_valid,
	output logic [`MINRV32_XLEN-1:0] mem_addr,
	output logic [`MINRV32_XLEN-1:0] mem_wdata,
	output logic [3:0]               mem_wstrb,
	output logic                     trap
);
	import minrv32_pkg::*;

	logic [`MINRV32_XLEN-1:0] pc;
	logic [`MINRV32_XLEN-1:0] pc_plus4;
	logic [`MINRV32_XLEN-1:0] pc_imm;
	logic [`MINRV32_XLEN-1:0] next_pc;
	logic                     jump;
	logic                     trap_now;
	logic                     trap_q;
	logic                     mem_ok;

	assign insn_addr = {pc[`MINRV32_XLEN-1:1], 1'b0};
	assign pc_plus4  = pc + 32'd4;
	assign pc_imm    = pc + imm;

	always_comb begin
		next_pc = pc_plus4;
		if (is_jalr)
			next_pc = {alu_result[`MINRV32_XLEN-1:1], 1'b0};  // rs1 + imm
		else if (is_jal || (is_branch && branch_taken))
			next_pc = pc_imm;
	end

	assign jump     = is_jal || is_jalr || (is_branch && branch_taken);
	assign trap_now = insn_valid && operands_ready && (illegal || (jump && next_pc[1]));
	assign trap     = trap_now || trap_q;

	// a trap halts the core until reset
	always_ff @(posedge clk) begin
		if (!resetn)
			trap_q <= 1'b0;
		else if (trap_now)
			trap_q <= 1'b1;
	end

	assign mem_valid = insn_valid && operands_ready && (is_load || is_store) && !trap;
	assign mem_addr  = alu_result;
	assign mem_wdata = rs2_value;
	assign mem_ok    = !(is_load || is_store) || mem_ready;

	assign insn_complete = insn_valid && operands_ready && mem_ok && !trap;
	assign mem_wstrb     = (is_store && insn_complete) ? 4'b1111 : 4'b0000;

	always_comb begin
		case (wb_sel)
			WB_IMM:  rd_wdata = pc_imm;
			WB_PC4:  rd_wdata = pc_plus4;
			WB_MEM:  rd_wdata = mem_rdata;
			default: rd_wdata = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			pc <= `MINRV32_PROGADDR_RESET;
		else if (insn_complete)
			pc <= next_pc;
	end

	a_wstrb_handshake: assert property (@(posedge clk) disable iff (!resetn)
		mem_wstrb != 4'b0 |-> mem_valid && mem_ready && rs1_value + imm == mem_addr);

	// a waiting request keeps its address and data
	a_req_held: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata));

endmodule

//--- minrv32.sv
`include "minrv32_params.svh"

module minrv32 (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic [`MINRV32_XLEN-1:0] insn,
	input  logic                     insn_valid,
	input  logic                     mem_ready,
	input  logic [`MINRV32_XLEN-1:0] mem_rdata,
	output logic [`MINRV32_XLEN-1:0] insn_addr,
	output logic                     mem_valid,
	output logic [`MINRV32_XLEN-1:0] mem_addr,
	output logic [`MINRV32_XLEN-1:0] mem_wdata,
	output logic [3:0]               mem_wstrb,
	output logic                     trap
);
	import minrv32_pkg::*;

	logic [`MINRV32_REG_AW-1:0] rs1_addr;
	logic [`MINRV32_REG_AW-1:0] rs2_addr;
	logic [`MINRV32_REG_AW-1:0] rd_addr;
	logic                       rs1_used;
	logic                       rs2_used;
	logic                       rd_we;
	logic [`MINRV32_XLEN-1:0]   imm;
	alu_op_t                    alu_op;
	logic                       use_imm;
	wb_sel_t                    wb_sel;
	logic                       is_jal;
	logic                       is_jalr;
	logic                       is_branch;
	logic                       is_load;
	logic                       is_store;
	logic                       illegal;
	logic [`MINRV32_XLEN-1:0]   rs1_value;
	logic [`MINRV32_XLEN-1:0]   rs2_value;
	logic                       operands_ready;
	logic [`MINRV32_XLEN-1:0]   rd_wdata;
	logic                       insn_complete;
	logic [`MINRV32_XLEN-1:0]   alu_result;
	logic                       branch_taken;
	branch_cond_t               branch_cond;

	assign branch_cond = branch_cond_t'(insn[14:12]);  // funct3

	minrv32_decode u_decode (
		.insn      (insn),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rd_addr   (rd_addr),
		.rs1_used  (rs1_used),
		.rs2_used  (rs2_used),
		.rd_we     (rd_we),
		.imm       (imm),
		.alu_op    (alu_op),
		.use_imm   (use_imm),
		.wb_sel    (wb_sel),
		.is_jal    (is_jal),
		.is_jalr   (is_jalr),
		.is_branch (is_branch),
		.is_load   (is_load),
		.is_store  (is_store),
		.illegal   (illegal)
	);

	minrv32_operand_fetch u_operand_fetch (
		.clk            (clk),
		.resetn         (resetn),
		.rs1_addr       (rs1_addr),
		.rs2_addr       (rs2_addr),
		.rs1_used       (rs1_used),
		.rs2_used       (rs2_used),
		.rd_addr        (rd_addr),
		.rd_we          (rd_we),
		.rd_wdata       (rd_wdata),
		.insn_complete  (insn_complete),
		.rs1_value      (rs1_value),
		.rs2_value      (rs2_value),
		.operands_ready (operands_ready)
	);

	minrv32_alu u_alu (
		.rs1_value    (rs1_value),
		.rs2_value    (rs2_value),
		.imm          (imm),
		.use_imm      (use_imm),
		.alu_op       (alu_op),
		.branch_cond  (branch_cond),
		.result       (alu_result),
		.branch_taken (branch_taken)
	);

	minrv32_exec u_exec (
		.clk            (clk),
		.resetn         (resetn),
		.insn_valid     (insn_valid),
		.operands_ready (operands_ready),
		.imm            (imm),
		.wb_sel         (wb_sel),
		.is_jal         (is_jal),
		.is_jalr        (is_jalr),
		.is_branch      (is_branch),
		.is_load        (is_load),
		.is_store       (is_store),
		.illegal        (illegal),
		.alu_result     (alu_result),
		.branch_taken   (branch_taken),
		.rs1_value      (rs1_value),
		.rs2_value      (rs2_value),
		.mem_ready      (mem_ready),
		.mem_rdata      (mem_rdata),
		.insn_addr      (insn_addr),
		.rd_wdata       (rd_wdata),
		.insn_complete  (insn_complete),
		.mem_valid      (mem_valid),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_wstrb      (mem_wstrb),
		.trap           (trap)
	);

endmodule

//--- minrv32_tb_clock.sv
module minrv32_tb_clock (
	output logic clk,
	output logic resetn
);
	logic       clk_q    = 1'b0;
	logic       rst_done = 1'b0;
	logic [2:0] rst_cnt  = 3'd0;

	assign clk    = clk_q;
	assign resetn = rst_done;

	always #50 clk_q = ~clk_q;  // period 100

	// reset low for the first 5 rising edges
	always @(posedge clk_q) begin
		if (rst_cnt != 3'd5)
			rst_cnt <= rst_cnt + 3'd1;
		if (rst_cnt == 3'd4)
			rst_done <= 1'b1;
	end

endmodule

//--- minrv32_tb_checker.sv
`include "minrv32_params.svh"

module minrv32_tb_checker (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic [`MINRV32_XLEN-1:0] insn_addr,
	input  logic                     mem_valid,
	input  logic                     mem_ready,
	input  logic [`MINRV32_XLEN-1:0] mem_addr,
	input  logic [`MINRV32_XLEN-1:0] mem_wdata,
	input  logic [3:0]               mem_wstrb,
	input  logic                     trap,
	input  logic [`MINRV32_XLEN-1:0] exp_addr [64],
	input  logic [`MINRV32_XLEN-1:0] exp_data [64],
	input  int                       store_count,
	input  logic [`MINRV32_XLEN-1:0] trap_addr,
	input  logic                     final_check,
	output int                       mismatches,
	output int                       failures
);
	int                       mismatch_count = 0;
	int                       failure_count  = 0;
	int                       next_store;
	logic                     trap_seen;
	logic                     req_waiting;  // request open, no mem_ready yet
	logic [`MINRV32_XLEN-1:0] req_addr;
	logic [`MINRV32_XLEN-1:0] req_wdata;

	assign mismatches = mismatch_count;
	assign failures   = failure_count;

	always @(posedge clk) begin
		if (!resetn) begin
			next_store  <= 0;
			trap_seen   <= 1'b0;
			req_waiting <= 1'b0;
		end else begin
			if (mem_wstrb != 4'b0 && mem_valid !== 1'b1) begin
				$display("MISMATCH mem_valid: got %h, expected 1 with mem_wstrb %h",
					mem_valid, mem_wstrb);
				mismatch_count = mismatch_count + 1;
			end
			// an open request holds until mem_ready
			if (req_waiting) begin
				if (mem_valid !== 1'b1) begin
					$display("memory request to %h dropped before mem_ready", req_addr);
					failure_count = failure_count + 1;
				end else begin
					if (mem_addr !== req_addr) begin
						$display("MISMATCH mem_addr: got %h, expected %h (held request)",
							mem_addr, req_addr);
						mismatch_count = mismatch_count + 1;
					end
					if (mem_wdata !== req_wdata) begin
						$display("MISMATCH mem_wdata: got %h, expected %h (held request)",
							mem_wdata, req_wdata);
						mismatch_count = mismatch_count + 1;
					end
				end
			end
			if (trap_seen && mem_valid !== 1'b0) begin
				$display("memory request raised after the core trapped");
				failure_count = failure_count + 1;
			end
			req_waiting <= (mem_valid === 1'b1) && !mem_ready;
			req_addr    <= mem_addr;
			req_wdata   <= mem_wdata;
			if (mem_wstrb != 4'b0) begin  // store completing this cycle
				if (trap_seen) begin
					$display("store to %h after the core trapped", mem_addr);
					failure_count = failure_count + 1;
				end else if (next_store >= store_count) begin
					$display("unexpected store to %h past the last expected one", mem_addr);
					failure_count = failure_count + 1;
				end else begin
					if (mem_addr !== exp_addr[next_store[5:0]]) begin
						$display("MISMATCH mem_addr: got %h, expected %h (store %0d)",
							mem_addr, exp_addr[next_store[5:0]], next_store);
						mismatch_count = mismatch_count + 1;
					end
					if (mem_wdata !== exp_data[next_store[5:0]]) begin
						$display("MISMATCH mem_wdata: got %h, expected %h (store %0d)",
							mem_wdata, exp_data[next_store[5:0]], next_store);
						mismatch_count = mismatch_count + 1;
					end
				end
				next_store <= next_store + 1;
			end
			if (trap && !trap_seen) begin
				trap_seen <= 1'b1;
				// only the final illegal word may trap
				if (insn_addr !== trap_addr) begin
					$display("MISMATCH insn_addr at trap: got %h, expected %h",
						insn_addr, trap_addr);
					mismatch_count = mismatch_count + 1;
				end
			end
			if (!trap && trap_seen) begin
				$display("trap went low again before reset");
				failure_count = failure_count + 1;
			end
		end
		if (final_check && next_store != store_count) begin
			$display("only %0d of %0d expected stores were seen", next_store, store_count);
			failure_count = failure_count + 1;
		end
	end

endmodule

//--- minrv32_tb.sv
`include "minrv32_params.svh"

module minrv32_tb;
	import minrv32_pkg::*;

	localparam int max_words    = 128;
	localparam int max_stores   = 64;
	localparam int stall_margin = 200;  // random mem_ready stalls

	logic                     clk;
	logic                     resetn;
	logic [`MINRV32_XLEN-1:0] insn;
	logic                     insn_valid;
	logic                     mem_ready = 1'b0;
	logic [`MINRV32_XLEN-1:0] mem_rdata;
	logic [`MINRV32_XLEN-1:0] insn_addr;
	logic                     mem_valid;
	logic [`MINRV32_XLEN-1:0] mem_addr;
	logic [`MINRV32_XLEN-1:0] mem_wdata;
	logic [3:0]               mem_wstrb;
	logic                     trap;

	logic [31:0] prog [max_words];
	logic [31:0] dmem [256];
	logic [31:0] exp_addr [max_stores];
	logic [31:0] exp_data [max_stores];
	logic [31:0] insn_off;
	logic [31:0] trap_addr;
	logic [31:0] slot;
	logic [31:0] rnd;
	integer      seed = 32'h2b6e;
	int          prog_len = 0;
	int          n_exp = 0;
	int          mismatches;
	int          failures;
	int          timeouts = 0;
	int          cycles;
	int          limit;
	logic        final_check = 1'b0;

	minrv32_tb_clock u_clock (
		.clk    (clk),
		.resetn (resetn)
	);

	minrv32 u_minrv32 (
		.clk        (clk),
		.resetn     (resetn),
		.insn       (insn),
		.insn_valid (insn_valid),
		.mem_ready  (mem_ready),
		.mem_rdata  (mem_rdata),
		.insn_addr  (insn_addr),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wstrb  (mem_wstrb),
		.trap       (trap)
	);

	minrv32_tb_checker u_checker (
		.clk         (clk),
		.resetn      (resetn),
		.insn_addr   (insn_addr),
		.mem_valid   (mem_valid),
		.mem_ready   (mem_ready),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_wstrb   (mem_wstrb),
		.trap        (trap),
		.exp_addr    (exp_addr),
		.exp_data    (exp_data),
		.store_count (n_exp),
		.trap_addr   (trap_addr),
		.final_check (final_check),
		.mismatches  (mismatches),
		.failures    (failures)
	);

	// instruction memory, words past the program are illegal
	assign insn_off   = insn_addr - `MINRV32_PROGADDR_RESET;
	assign insn       = (insn_off[31:9] == 23'b0) ? prog[insn_off[8:2]] : 32'h0;
	assign insn_valid = resetn;

	assign mem_rdata = dmem[mem_addr[9:2]];

	always @(posedge clk) begin
		if (mem_wstrb == 4'b1111)
			dmem[mem_addr[9:2]] <= mem_wdata;
	end

	always @(posedge clk) begin
		rnd = $random(seed);
		mem_ready <= rnd[1:0] != 2'b00;  // stall about one cycle in four
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] upper, input logic [4:0] rd,
		input logic [6:0] opc);
		return {upper, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] here();
		return `MINRV32_PROGADDR_RESET + 4 * prog_len;  // pc of the next word
	endfunction

	task automatic append(input logic [31:0] word);
		prog[prog_len[6:0]] = word;
		prog_len = prog_len + 1;
	endtask

	task automatic sw_at(input logic [31:0] addr, input logic [4:0] rs2,
		input logic [31:0] data);
		exp_addr[n_exp[5:0]] = addr;
		exp_data[n_exp[5:0]] = data;
		n_exp = n_exp + 1;
		append(s_type(addr[11:0], rs2, 5'd0));
	endtask

	// next free result word
	task automatic sw_checked(input logic [4:0] rs2, input logic [31:0] data);
		sw_at(slot, rs2, data);
		slot = slot + 32'd4;
	endtask

	task automatic sw_skipped();
		append(s_type(12'h3f0, 5'd7, 5'd0));  // on a path that must not run
	endtask

	task automatic taken_branch(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2);
		append(b_type(13'd8, rs2, rs1, f3));
		sw_skipped();
	endtask

	task automatic fallthrough_branch(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2);
		append(b_type(13'd8, rs2, rs1, f3));
		sw_checked(5'd0, 32'h0);
	endtask

	initial begin
		logic [31:0] v5;
		logic [31:0] v7;
		logic [31:0] v8;
		logic [31:0] pc;

		// system opcode tagged with the word index, traps if ever fetched
		for (int i = 0; i < max_words; i++)
			prog[i[6:0]] = {18'h0, i[6:0], 7'b1110011};
		slot = 32'h100;
		v5   = 32'h1234_5000;
		v7   = v5 + 32'h678;
		v8   = 32'hffff_fffb;  // -5

		sw_checked(5'd0, 32'h0);  // x0 and sp straight out of reset
		sw_checked(5'd2, `MINRV32_STACKADDR);
		append(u_type(20'h12345, 5'd5, OPC_LUI));
		sw_checked(5'd5, v5);
		pc = here();
		append(u_type(20'h00001, 5'd6, OPC_AUIPC));
		sw_checked(5'd6, pc + 32'h1000);
		append(i_type(12'h678, 5'd5, 3'b000, 5'd7, OPC_OP_IMM));
		sw_checked(5'd7, v7);
		append(i_type(12'hffb, 5'd0, 3'b000, 5'd8, OPC_OP_IMM));
		sw_checked(5'd8, v8);
		append(r_type(7'h00, 5'd8, 5'd7, 3'b000, 5'd9));   // add
		sw_checked(5'd9, v7 + v8);
		append(r_type(7'h20, 5'd8, 5'd7, 3'b000, 5'd10));  // sub
		sw_checked(5'd10, v7 - v8);
		append(r_type(7'h00, 5'd8, 5'd7, 3'b100, 5'd11));
		sw_checked(5'd11, v7 ^ v8);
		append(r_type(7'h00, 5'd8, 5'd7, 3'b110, 5'd12));
		sw_checked(5'd12, v7 | v8);
		append(r_type(7'h00, 5'd8, 5'd7, 3'b111, 5'd13));
		sw_checked(5'd13, v7 & v8);
		// shift amount 36 uses only its low 5 bits
		append(i_type(12'd36, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
		append(r_type(7'h00, 5'd14, 5'd7, 3'b001, 5'd15));
		sw_checked(5'd15, 32'h2345_6780);
		append(r_type(7'h00, 5'd14, 5'd8, 3'b101, 5'd16));
		sw_checked(5'd16, 32'h0fff_ffff);
		append(r_type(7'h20, 5'd14, 5'd8, 3'b101, 5'd17));
		sw_checked(5'd17, 32'hffff_ffff);
		append(r_type(7'h00, 5'd7, 5'd8, 3'b010, 5'd18));  // slt, -5 < x7
		sw_checked(5'd18, 32'h1);
		append(r_type(7'h00, 5'd7, 5'd8, 3'b011, 5'd19));  // sltu, x8 is huge
		sw_checked(5'd19, 32'h0);
		append(r_type(7'h00, 5'd7, 5'd7, 3'b000, 5'd0));   // write to x0 is lost
		sw_checked(5'd0, 32'h0);

		// store, load back, store again
		sw_at(32'h300, 5'd7, v7);
		append(i_type(12'h300, 5'd0, 3'b010, 5'd20, OPC_LOAD));
		sw_checked(5'd20, v7);
		sw_at(32'h304, 5'd10, v7 - v8);
		append(i_type(12'h304, 5'd0, 3'b010, 5'd21, OPC_LOAD));
		sw_checked(5'd21, v7 - v8);

		// x7 positive, x8 negative
		taken_branch(BR_BEQ, 5'd7, 5'd7);
		fallthrough_branch(BR_BEQ, 5'd7, 5'd8);
		taken_branch(BR_BNE, 5'd7, 5'd8);
		fallthrough_branch(BR_BNE, 5'd7, 5'd7);
		taken_branch(BR_BLT, 5'd8, 5'd7);
		fallthrough_branch(BR_BLT, 5'd7, 5'd8);
		taken_branch(BR_BGE, 5'd7, 5'd8);
		fallthrough_branch(BR_BGE, 5'd8, 5'd7);
		taken_branch(BR_BLTU, 5'd7, 5'd8);
		fallthrough_branch(BR_BLTU, 5'd8, 5'd7);
		taken_branch(BR_BGEU, 5'd8, 5'd7);
		fallthrough_branch(BR_BGEU, 5'd7, 5'd8);

		pc = here();
		append(j_type(21'd8, 5'd22));
		sw_skipped();
		sw_checked(5'd22, pc + 32'd4);  // link
		pc = here();
		append(u_type(20'h0, 5'd23, OPC_AUIPC));
		append(i_type(12'd17, 5'd23, 3'b000, 5'd24, OPC_JALR));  // lands on pc + 16
		sw_skipped();
		sw_skipped();
		sw_checked(5'd24, pc + 32'd8);

		trap_addr = here();
		append(32'h0000_0073);  // ecall, illegal in this core
		limit = prog_len * 3 + stall_margin;

		@(negedge clk);
		while (!resetn)
			@(negedge clk);
		cycles = 0;
		while (!trap && cycles < limit) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!trap) begin
			$display("timeout: no trap within %0d cycles", limit);
			timeouts = 1;
		end
		repeat (4) @(negedge clk);  // trap must hold, no more stores
		final_check = 1'b1;
		@(negedge clk);
		final_check = 1'b0;
		@(negedge clk);
		$display("errors: %0d mismatches, %0d other", mismatches, failures + timeouts);
		if (mismatches + failures + timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- minrv32.f
+incdir+.
minrv32_pkg.sv
minrv32_decode.sv
minrv32_operand_fetch.sv
minrv32_alu.sv
minrv32_exec.sv
minrv32.sv
minrv32_tb_clock.sv
minrv32_tb_checker.sv
minrv32_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the minrv32 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module minrv32_tb -Mdir obj_dir -f minrv32.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vminrv32_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
